/* logic/core.sv */
module core import corePkg::*; #(
    parameter int ADDR_W = DEF_ADDR_W,
    parameter int DATA_W = DEF_DATA_W
) (
    // Common signals.
    input  logic              i_clk,
    input  logic              i_arstN,

    // Boot and pause control.
    input  logic              i_isBooted,
    input  logic              i_startPause,
    output logic              o_nowPaused,

    // Address of the next fetch.
    output logic [ADDR_W-1:0] o_pcValue,

    // Unified memory bus.
    output logic [ADDR_W-1:0] o_memAddr,
    output logic              o_memRd,
    output logic              o_memWr,
    output logic [DATA_W-1:0] o_memWrData,
    input  logic [DATA_W-1:0] i_memRdData,

    // Data access port.
    input  logic              i_dValid,
    output logic              o_dReady,
    input  logic [ADDR_W-1:0] i_dAddr,
    input  memOp_t            i_dOp,
    input  logic [DATA_W-1:0] i_dWrData,
    output logic              o_dRdValid,
    output logic [DATA_W-1:0] o_dRdData,

    // Fetched instruction stream.
    output logic              o_instrValid,
    input  logic              i_instrReady,
    output logic [DATA_W-1:0] o_instr,
    output logic [ADDR_W-1:0] o_instrPc
);

    // ----------------------------------------------------------
    // Request channels into the arbiter.
    // ----------------------------------------------------------

    memReqIf #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) instrChan ();
    memReqIf #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) dataChan ();

    // Instruction fetch.
    fetchUnit #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) uFetch (
        .i_clk        (i_clk),
        .i_arstN      (i_arstN),
        .i_isBooted   (i_isBooted),
        .i_startPause (i_startPause),
        .chan         (instrChan.requester),
        .o_nowPaused  (o_nowPaused),
        .o_pcValue    (o_pcValue),
        .o_instrValid (o_instrValid),
        .i_instrReady (i_instrReady),
        .o_instr      (o_instr),
        .o_instrPc    (o_instrPc)
    );

    // Data access buffering.
    dataPort #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) uData (
        .i_clk      (i_clk),
        .i_arstN    (i_arstN),
        .i_dValid   (i_dValid),
        .o_dReady   (o_dReady),
        .i_dAddr    (i_dAddr),
        .i_dOp      (i_dOp),
        .i_dWrData  (i_dWrData),
        .o_dRdValid (o_dRdValid),
        .o_dRdData  (o_dRdData),
        .chan       (dataChan.requester)
    );

    // Bus scheduling, data before fetch.
    memArbiter #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) uArb (
        .i_clk       (i_clk),
        .i_arstN     (i_arstN),
        .instrChan   (instrChan.arbiter),
        .dataChan    (dataChan.arbiter),
        .o_memAddr   (o_memAddr),
        .o_memRd     (o_memRd),
        .o_memWr     (o_memWr),
        .o_memWrData (o_memWrData),
        .i_memRdData (i_memRdData)
    );

endmodule

/* logic/corePkg.sv */
package corePkg;

    // ----------------------------------------------------------
    // Default widths.
    // ----------------------------------------------------------

    // Word address width of the unified memory.
    localparam int DEF_ADDR_W = 15;

    // Width of one memory word and of one instruction.
    localparam int DEF_DATA_W = 16;

    // ----------------------------------------------------------
    // Memory operations.
    // ----------------------------------------------------------

    // Operation carried by a request channel.
    // A swap reads the old word and then writes the new one.
    typedef enum logic [1:0] {
        MEM_READ  = 2'd0,
        MEM_WRITE = 2'd1,
        MEM_SWAP  = 2'd2
    } memOp_t;

    // ----------------------------------------------------------
    // Arbiter sequencing.
    // ----------------------------------------------------------

    // Idle takes a new request.
    // Swap write is the second bus cycle of a swap.
    typedef enum logic {
        ARB_IDLE    = 1'b0,
        ARB_SWAP_WR = 1'b1
    } arbState_t;

endpackage

/* logic/dataPort.sv */
module dataPort import corePkg::*; #(
    parameter int ADDR_W = DEF_ADDR_W,
    parameter int DATA_W = DEF_DATA_W
) (
    input  logic              i_clk,
    input  logic              i_arstN,

    // External data request.
    input  logic              i_dValid,
    output logic              o_dReady,
    input  logic [ADDR_W-1:0] i_dAddr,
    input  memOp_t            i_dOp,
    input  logic [DATA_W-1:0] i_dWrData,

    // External read response.
    output logic              o_dRdValid,
    output logic [DATA_W-1:0] o_dRdData,

    // Data channel to the arbiter.
    memReqIf.requester        chan
);

    // ----------------------------------------------------------
    // One-entry request buffer.
    // ----------------------------------------------------------

    logic              bufValid;
    logic [ADDR_W-1:0] bufAddr;
    memOp_t            bufOp;
    logic [DATA_W-1:0] bufWrData;
    logic              handOff;
    logic              expInc;
    logic [1:0]        expCnt;

    assign handOff  = chan.valid && chan.ready;
    // Free now, or freed by the arbiter this cycle.
    assign o_dReady = !bufValid || handOff;

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            bufValid <= 1'b0;
        end else if (i_dValid && o_dReady) begin
            bufValid <= 1'b1;
        end else if (handOff) begin
            bufValid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_dValid && o_dReady) begin
            bufAddr   <= i_dAddr;
            bufOp     <= i_dOp;
            bufWrData <= i_dWrData;
        end
    end

    assign chan.valid  = bufValid;
    assign chan.addr   = bufAddr;
    assign chan.op     = bufOp;
    assign chan.wrData = bufWrData;

    // ----------------------------------------------------------
    // Response tracking.
    // ----------------------------------------------------------

    // Reads and swaps each owe one response, writes none.
    assign expInc = handOff && (chan.op != MEM_WRITE);

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            expCnt <= 2'd0;
        end else begin
            case ({expInc, chan.rdValid})
                2'b10:   expCnt <= expCnt + 2'd1;
                2'b01:   expCnt <= expCnt - 2'd1;
                default: expCnt <= expCnt;
            endcase
        end
    end

    assign o_dRdValid = chan.rdValid;
    assign o_dRdData  = chan.rdData;

    dataNoStrayA: assert property (@(posedge i_clk) disable iff (!i_arstN)
        chan.rdValid |-> expCnt != 2'd0);

    // Waiting request keeps its fields until the arbiter takes it.
    dataHoldA: assert property (@(posedge i_clk) disable iff (!i_arstN)
        chan.valid && !chan.ready |=> chan.valid && $stable(chan.addr)
            && $stable(chan.op) && $stable(chan.wrData));

endmodule

/* logic/fetchUnit.sv */
module fetchUnit import corePkg::*; #(
    parameter int ADDR_W = DEF_ADDR_W,
    parameter int DATA_W = DEF_DATA_W
) (
    // Clock, reset and core control.
    input  logic              i_clk,
    input  logic              i_arstN,
    input  logic              i_isBooted,
    input  logic              i_startPause,

    // Instruction read channel.
    memReqIf.requester        chan,

    // Pause status and next fetch address.
    output logic              o_nowPaused,
    output logic [ADDR_W-1:0] o_pcValue,

    // Fetched instruction output.
    output logic              o_instrValid,
    input  logic              i_instrReady,
    output logic [DATA_W-1:0] o_instr,
    output logic [ADDR_W-1:0] o_instrPc
);

    // ----------------------------------------------------------
    // Fetch state.
    // ----------------------------------------------------------

    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] pendPc;
    logic              rdPending;
    logic              outFree;
    logic              fetchAccept;

    // Output register is empty, or it drains this cycle.
    assign outFree = !o_instrValid || i_instrReady;

    // Only one read in flight, and its return always has room.
    assign chan.valid  = i_isBooted && !i_startPause && !rdPending && outFree;
    assign chan.addr   = pc;
    assign chan.op     = MEM_READ;
    assign chan.wrData = '0;

    assign fetchAccept = chan.valid && chan.ready;

    // ----------------------------------------------------------
    // PC and outstanding read.
    // ----------------------------------------------------------

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            pc        <= '0;
            rdPending <= 1'b0;
        end else begin
            // Boot holds the PC at zero.
            if (!i_isBooted) begin
                pc <= '0;
            end else if (fetchAccept) begin
                pc <= pc + 1'b1;
            end
            // Return comes exactly one cycle after acceptance.
            rdPending <= fetchAccept;
        end
    end

    // PC of the read in flight.
    always_ff @(posedge i_clk) begin
        if (fetchAccept) begin
            pendPc <= pc;
        end
    end

    // ----------------------------------------------------------
    // Instruction output register.
    // ----------------------------------------------------------

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_instrValid <= 1'b0;
        end else if (chan.rdValid) begin
            o_instrValid <= 1'b1;
        end else if (i_instrReady) begin
            o_instrValid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (chan.rdValid) begin
            o_instr   <= chan.rdData;
            o_instrPc <= pendPc;
        end
    end

    assign o_nowPaused = i_startPause && !rdPending;
    assign o_pcValue   = pc;

    // The arbiter returns an accepted fetch in the next cycle.
    fetchReturnA: assert property (@(posedge i_clk) disable iff (!i_arstN)
        fetchAccept |=> chan.rdValid);

    // Stalled output holds its contents.
    instrHoldA: assert property (@(posedge i_clk) disable iff (!i_arstN)
        o_instrValid && !i_instrReady |=>
            o_instrValid && $stable(o_instr) && $stable(o_instrPc));

    // No stray read return.
    fetchNoStrayA: assert property (@(posedge i_clk) disable iff (!i_arstN)
        chan.rdValid |-> rdPending);

endmodule

/* logic/memArbiter.sv */
module memArbiter import corePkg::*; #(
    parameter int ADDR_W = DEF_ADDR_W,
    parameter int DATA_W = DEF_DATA_W
) (
    input  logic              i_clk,
    input  logic              i_arstN,

    // Requesters, data first.
    memReqIf.arbiter          instrChan,
    memReqIf.arbiter          dataChan,

    // Unified memory bus.
    output logic [ADDR_W-1:0] o_memAddr,
    output logic              o_memRd,
    output logic              o_memWr,
    output logic [DATA_W-1:0] o_memWrData,
    input  logic [DATA_W-1:0] i_memRdData
);

    // ----------------------------------------------------------
    // Grant logic.
    // ----------------------------------------------------------

    arbState_t         state;
    logic              isIdle;
    logic              dataGrant;
    logic              instrGrant;
    logic              dataSwap;
    logic [ADDR_W-1:0] swapAddr;
    logic [DATA_W-1:0] swapData;
    logic              rdToData;
    logic              rdToInstr;

    assign isIdle = (state == ARB_IDLE);

    // Data always wins; fetch only sees ready when data is quiet.
    assign dataChan.ready  = isIdle;
    assign instrChan.ready = isIdle && !dataChan.valid;

    assign dataGrant  = dataChan.valid && dataChan.ready;
    assign instrGrant = instrChan.valid && instrChan.ready;
    assign dataSwap   = dataGrant && (dataChan.op == MEM_SWAP);

    // ----------------------------------------------------------
    // Bus drive.
    // ----------------------------------------------------------

    always_comb begin
        o_memAddr   = '0;
        o_memRd     = 1'b0;
        o_memWr     = 1'b0;
        o_memWrData = '0;
        if (state == ARB_SWAP_WR) begin
            // Second half of a swap.
            o_memAddr   = swapAddr;
            o_memWr     = 1'b1;
            o_memWrData = swapData;
        end else if (dataGrant) begin
            o_memAddr   = dataChan.addr;
            o_memRd     = (dataChan.op != MEM_WRITE);
            o_memWr     = (dataChan.op == MEM_WRITE);
            o_memWrData = dataChan.wrData;
        end else if (instrGrant) begin
            o_memAddr = instrChan.addr;
            o_memRd   = 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Swap sequencing and read return routing.
    // ----------------------------------------------------------

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            state     <= ARB_IDLE;
            rdToData  <= 1'b0;
            rdToInstr <= 1'b0;
        end else begin
            state     <= dataSwap ? ARB_SWAP_WR : ARB_IDLE;
            // Owner of the data word that the memory returns next cycle.
            rdToData  <= dataGrant && (dataChan.op != MEM_WRITE);
            rdToInstr <= instrGrant;
        end
    end

    // New word and address for the write half.
    always_ff @(posedge i_clk) begin
        if (dataSwap) begin
            swapAddr <= dataChan.addr;
            swapData <= dataChan.wrData;
        end
    end

    assign dataChan.rdValid  = rdToData;
    assign dataChan.rdData   = rdToData ? i_memRdData : '0;
    assign instrChan.rdValid = rdToInstr;
    assign instrChan.rdData  = rdToInstr ? i_memRdData : '0;

    busExclusiveA: assert property (@(posedge i_clk) disable iff (!i_arstN)
        !(o_memRd && o_memWr));

    // One user of the bus per cycle, swap write included.
    oneGrantA: assert property (@(posedge i_clk) disable iff (!i_arstN)
        $onehot0({instrGrant, dataGrant, state == ARB_SWAP_WR}));

endmodule

/* logic/memReqIf.sv */
interface memReqIf import corePkg::*; #(
    parameter int ADDR_W = DEF_ADDR_W,
    parameter int DATA_W = DEF_DATA_W
) ();

    // Request side, driven by the requester.
    // Fields are held stable while valid waits for ready.
    logic              valid;
    logic [ADDR_W-1:0] addr;
    memOp_t            op;
    logic [DATA_W-1:0] wrData;

    // Handshake and read return, driven by the arbiter.
    // rdValid follows an accepted read or swap by one cycle.
    logic              ready;
    logic              rdValid;
    logic [DATA_W-1:0] rdData;

    // Fetch unit and data port side.
    modport requester (
        output valid, addr, op, wrData,
        input  ready, rdValid, rdData
    );

    // Memory arbiter side.
    modport arbiter (
        input  valid, addr, op, wrData,
        output ready, rdValid, rdData
    );

endinterface

/* test/tbCore.sv */
module tbCore import corePkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W     = 15;
    localparam int DATA_W     = 16;
    localparam int CLK_NS     = 40;
    localparam int MEM_WORDS  = 1024;
    // Fetches stay below this word, data traffic above it.
    localparam int PROG_WORDS = 512;
    localparam int BOOT_INSTR = 40;
    localparam int BP_INSTR   = 80;
    localparam int SOLO_OPS   = 60;
    localparam int MIX_OPS    = 100;
    localparam int NUM_TXN    = BOOT_INSTR + BP_INSTR + SOLO_OPS + MIX_OPS + 2;

    typedef struct packed {
        memOp_t            op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } dataReq_t;

    logic              i_clk, i_arstN, i_isBooted, i_startPause, o_nowPaused;
    logic [ADDR_W-1:0] o_pcValue, o_memAddr, i_dAddr, o_instrPc;
    logic              o_memRd, o_memWr, i_dValid, o_dReady, o_dRdValid;
    logic [DATA_W-1:0] o_memWrData, i_memRdData, i_dWrData, o_dRdData, o_instr;
    memOp_t            i_dOp;
    logic              o_instrValid, i_instrReady;

    // Shadow memory and expected traffic.
    logic [DATA_W-1:0] shadow [MEM_WORDS];
    logic [DATA_W-1:0] expRdQ [$];
    dataReq_t          busQ [$];
    dataReq_t          busReq, swapReq;
    logic              swapPend;
    logic [ADDR_W-1:0] expPc;
    // Address of the next fetch read, and a fetch read in flight.
    logic [ADDR_W-1:0] fetchPc;
    logic              fetchInFlight;
    int                instrCount, pausedCount;
    logic              pauseQuiet, randReady;
    logic [DATA_W-1:0] word;

    core #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) dut (.*);

    tbMemModel #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .DEPTH(MEM_WORDS)) tbMem (
        .i_clk    (i_clk),
        .i_addr   (o_memAddr),
        .i_rd     (o_memRd),
        .i_wr     (o_memWr),
        .i_wrData (o_memWrData),
        .o_rdData (i_memRdData)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #(CLK_NS / 2) i_clk = ~i_clk;
        end
    end

    // ----------------------------------------------------------
    // Reference model and compare tasks.
    // ----------------------------------------------------------

    function automatic logic [DATA_W-1:0] refMem(input logic [ADDR_W-1:0] addr);
        return shadow[addr];
    endfunction

    // Bus op as seen on the strobes.
    function automatic memOp_t busOpSeen(input logic wr);
        if (wr) begin
            return MEM_WRITE;
        end
        return MEM_READ;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input logic [DATA_W-1:0] expVal,
                             input logic [DATA_W-1:0] actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("** Error at %0t: %s expected %h, got %h",
                              $time, name, expVal, actVal));
        end
    endtask

    task automatic checkAddr(input string name, input logic [ADDR_W-1:0] expVal,
                             input logic [ADDR_W-1:0] actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("** Error at %0t: %s expected %h, got %h",
                              $time, name, expVal, actVal));
        end
    endtask

    task automatic checkOp(input string name, input memOp_t expVal, input memOp_t actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("** Error at %0t: %s expected %s, got %s",
                              $time, name, expVal.name(), actVal.name()));
        end
    endtask

    task automatic checkFlag(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("** Error at %0t: %s expected %b, got %b",
                              $time, name, expVal, actVal));
        end
    endtask

    // ----------------------------------------------------------
    // Monitor.
    // ----------------------------------------------------------

    always @(posedge i_clk) begin
        if (i_arstN) begin
            if (o_instrValid && (!i_isBooted || pauseQuiet)) begin
                failRun("An instruction came out while unbooted or paused.");
            end
            // Next fetch address, and pause once no fetch read is in flight.
            checkAddr("o_pcValue", fetchPc, o_pcValue);
            checkFlag("o_nowPaused", i_startPause && !fetchInFlight, o_nowPaused);
            fetchInFlight = o_memRd && (o_memAddr < PROG_WORDS);
            if (fetchInFlight) begin
                checkAddr("o_memAddr", fetchPc, o_memAddr);
                fetchPc++;
            end
            // Gapless, in-order instruction stream.
            if (o_instrValid && i_instrReady) begin
                if (o_instrPc >= PROG_WORDS) begin
                    failRun("Fetch ran past the program region.");
                end
                checkAddr("o_instrPc", expPc, o_instrPc);
                checkWord("o_instr", refMem(expPc), o_instr);
                expPc++;
                instrCount++;
            end
            // Data side of the bus, in acceptance order.
            if (swapPend) begin
                checkOp("bus op", MEM_WRITE, busOpSeen(o_memWr));
                checkAddr("o_memAddr", swapReq.addr, o_memAddr);
                checkWord("o_memWrData", swapReq.data, o_memWrData);
                swapPend = 1'b0;
            end else if ((o_memRd || o_memWr) && o_memAddr >= PROG_WORDS) begin
                if (busQ.size() == 0) begin
                    failRun("The bus touched data memory with no data request accepted.");
                end
                busReq = busQ.pop_front();
                checkAddr("o_memAddr", busReq.addr, o_memAddr);
                checkOp("bus op", busOpSeen(busReq.op == MEM_WRITE), busOpSeen(o_memWr));
                if (busReq.op == MEM_WRITE) begin
                    checkWord("o_memWrData", busReq.data, o_memWrData);
                end
                swapReq  = busReq;
                swapPend = (busReq.op == MEM_SWAP);
            end
            if (o_dRdValid) begin
                if (expRdQ.size() == 0) begin
                    failRun("A data response came with no read outstanding.");
                end
                checkWord("o_dRdData", expRdQ.pop_front(), o_dRdData);
            end
            // Accepted request updates the shadow.
            if (i_dValid && o_dReady) begin
                busQ.push_back('{i_dOp, i_dAddr, i_dWrData});
                if (i_dOp != MEM_WRITE) begin
                    expRdQ.push_back(refMem(i_dAddr));
                end
                if (i_dOp != MEM_READ) begin
                    shadow[i_dAddr] = i_dWrData;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Stimulus.
    // ----------------------------------------------------------

    always @(negedge i_clk) begin
        if (randReady) begin
            i_instrReady = 1'($urandom_range(1));
        end
    end

    // o_dReady depends on registers only, so it is stable at the falling edge.
    task automatic issueData(input memOp_t op, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data);
        i_dValid  = 1'b1;
        i_dOp     = op;
        i_dAddr   = addr;
        i_dWrData = data;
        while (!o_dReady) begin
            @(negedge i_clk);
        end
        @(negedge i_clk);
        i_dValid = 1'b0;
    endtask

    // Small address window so reads often hit earlier writes.
    task automatic runDataOps(input int count);
        int     pick;
        memOp_t op;
        for (int n = 0; n < count; n++) begin
            pick = $urandom_range(9);
            op   = (pick < 4) ? MEM_READ : ((pick < 8) ? MEM_WRITE : MEM_SWAP);
            issueData(op, ADDR_W'(PROG_WORDS + $urandom_range(31)), DATA_W'($urandom));
            repeat ($urandom_range(2)) @(negedge i_clk);
        end
    endtask

    initial begin
        #(CLK_NS * 200 * NUM_TXN);
        failRun("Watchdog expired. The run hung.");
    end

    initial begin
        void'($urandom(32'hd8f8_e425));
        i_arstN       = 1'b0;
        i_isBooted    = 1'b0;
        i_startPause  = 1'b0;
        i_dValid      = 1'b0;
        i_dAddr       = '0;
        i_dOp         = MEM_READ;
        i_dWrData     = '0;
        i_instrReady  = 1'b0;
        expPc         = '0;
        fetchPc       = '0;
        fetchInFlight = 1'b0;
        instrCount    = 0;
        pauseQuiet    = 1'b0;
        randReady     = 1'b0;
        swapPend      = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            word      = DATA_W'($urandom);
            shadow[i] = word;
            tbMem.loadWord(i, word);
        end
        repeat (5) @(negedge i_clk);
        i_arstN = 1'b1;

        // Unbooted core must stay quiet, then fetch from PC 0.
        repeat (20) @(negedge i_clk);
        i_isBooted   = 1'b1;
        i_instrReady = 1'b1;
        while (instrCount < BOOT_INSTR) @(negedge i_clk);

        // Random back-pressure on the instruction output.
        randReady = 1'b1;
        while (instrCount < BOOT_INSTR + BP_INSTR) @(negedge i_clk);

        // Pause, drain the output register, then run data traffic alone.
        randReady    = 1'b0;
        i_instrReady = 1'b1;
        i_startPause = 1'b1;
        do @(negedge i_clk); while (!o_nowPaused);
        repeat (2) @(negedge i_clk);
        pauseQuiet  = 1'b1;
        pausedCount = instrCount;
        issueData(MEM_SWAP, ADDR_W'(PROG_WORDS + 5), 16'ha5c3);
        issueData(MEM_READ, ADDR_W'(PROG_WORDS + 5), '0);
        runDataOps(SOLO_OPS);

        // Release and mix data with fetches.
        pauseQuiet   = 1'b0;
        i_startPause = 1'b0;
        randReady    = 1'b1;
        runDataOps(MIX_OPS);
        while (expRdQ.size() != 0 || busQ.size() != 0 || swapPend) @(negedge i_clk);
        repeat (4) @(negedge i_clk);

        if (instrCount == pausedCount) begin
            failRun("Fetching did not resume after the pause was released.");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

/* test/tbMemModel.sv */
module tbMemModel import corePkg::*; #(
    parameter int ADDR_W = DEF_ADDR_W,
    parameter int DATA_W = DEF_DATA_W,
    parameter int DEPTH  = 1024
) (
    input  logic              i_clk,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic              i_rd,
    input  logic              i_wr,
    input  logic [DATA_W-1:0] i_wrData,
    output logic [DATA_W-1:0] o_rdData
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [DATA_W-1:0] rdWord;

    initial begin
        o_rdData = '0;
        rdWord   = '0;
    end

    // Preload of one word before the run starts.
    task automatic loadWord(input int idx, input logic [DATA_W-1:0] word);
        mem[idx] = word;
    endtask

    // Bus is sampled at the rising edge.
    // A swap write one cycle later leaves the captured old word intact.
    always @(posedge i_clk) begin
        if (i_rd) begin
            rdWord <= mem[i_addr % DEPTH];
        end
        if (i_wr) begin
            mem[i_addr % DEPTH] <= i_wrData;
        end
    end

    // Read word shows up on the falling edge, one cycle after the read.
    always @(negedge i_clk) begin
        o_rdData <= rdWord;
    end

endmodule

/* verilog.f */
logic/corePkg.sv
logic/memReqIf.sv
logic/fetchUnit.sv
logic/dataPort.sv
logic/memArbiter.sv
logic/core.sv
test/tbMemModel.sv
test/tbCore.sv
